// File: hdl/alu.sv
/*
 * Integer ALU
 * Combinational 64-bit add, logic, shift and compare operations
 */
module alu
  import ex_pkg::*;
(
  input  logic [63:0] opa,
  input  logic [63:0] opb,
  input  alu_func_e   func,
  output logic [63:0] result
);

  logic signed [63:0] opa_s;
  logic signed [63:0] opb_s;
  logic [5:0]         shamt;

  assign opa_s = $signed(opa);
  assign opb_s = $signed(opb);
  assign shamt = opb[5:0];  // Only low 6 bits count

  always_comb
  begin
    result = '0;
    case (func)
      alu_addq:   result = opa + opb;
      alu_subq:   result = opa - opb;
      alu_and:    result = opa & opb;
      alu_bic:    result = opa & ~opb;
      alu_bis:    result = opa | opb;
      alu_ornot:  result = opa | ~opb;
      alu_xor:    result = opa ^ opb;
      alu_eqv:    result = opa ^ ~opb;
      alu_srl:    result = opa >> shamt;
      alu_sll:    result = opa << shamt;
      alu_sra:    result = opa_s >>> shamt;
      alu_mulq:   result = '0;  // Products come from the multiplier
      alu_cmpeq:  result = {63'b0, opa == opb};
      alu_cmplt:  result = {63'b0, opa_s < opb_s};
      alu_cmple:  result = {63'b0, opa_s <= opb_s};
      alu_cmpult: result = {63'b0, opa < opb};
      alu_cmpule: result = {63'b0, opa <= opb};
      default:    result = '0;
    endcase
  end

endmodule

// File: hdl/branch_unit.sv
/*
 * Branch resolution
 * Tests the condition on register A and flags a wrong predicted PC
 */
module branch_unit
  import ex_pkg::*;
(
  input  logic [63:0] rega,
  input  logic [2:0]  cond_code,
  input  logic        cond_br,
  input  logic        uncond_br,
  input  logic [63:0] target,
  input  logic [63:0] npc,
  input  logic [63:0] ppc,
  output logic        taken,
  output logic        mispredict
);

  logic cond_met;
  logic is_zero;
  logic is_neg;

  assign is_zero = (rega == '0);
  assign is_neg  = rega[63];

  always_comb
  begin
    case (br_cond_e'(cond_code))
      br_lbc:  cond_met = ~rega[0];
      br_eq:   cond_met = is_zero;
      br_lt:   cond_met = is_neg;
      br_le:   cond_met = is_neg | is_zero;
      br_lbs:  cond_met = rega[0];
      br_ne:   cond_met = ~is_zero;
      br_ge:   cond_met = ~is_neg;
      br_gt:   cond_met = ~is_neg & ~is_zero;
      default: cond_met = 1'b0;
    endcase
  end

  assign taken = uncond_br | (cond_br & cond_met);

  // Taken must match the target, fall-through must match npc
  assign mispredict = taken ? (target != ppc) : (ppc != npc);

endmodule

// File: hdl/ex_arbiter.sv
/*
 * Result bus arbiter
 * Memory beats multiplier beats ALU; registers the winner onto the result bus
 */
module ex_arbiter
  import ex_pkg::*;
(
  input  logic       clock,
  input  logic       rst_n,
  input  logic       alu_valid,
  input  ex_result_t alu_word,
  input  logic       mult_valid,
  input  ex_result_t mult_word,
  input  logic       mem_wb_valid,
  input  mem_wb_t    mem_wb,
  output logic       stall,
  output logic       mult_freeze,
  output ex_result_t result,
  output logic       result_valid
);

  ex_result_t next_word;
  logic       next_valid;

  ////////////////////////////////////////////////////////////
  // Priority select
  ////////////////////////////////////////////////////////////

  // Finished product waits while a load owns the bus
  assign mult_freeze = mult_valid & mem_wb_valid;

  // ALU op loses to either higher source
  assign stall = alu_valid & (mem_wb_valid | mult_valid);

  assign next_valid = mem_wb_valid | mult_valid | alu_valid;

  always_comb
  begin
    next_word = '0;
    if (mem_wb_valid)
    begin
      next_word.dest_reg = mem_wb.tag;
      next_word.result   = mem_wb.value;
    end
    else if (mult_valid)
    begin
      next_word               = mult_word;
      next_word.mispredict    = 1'b0;  // No branch info on products
      next_word.branch_result = 2'b00;
      next_word.pht_idx       = '0;
    end
    else if (alu_valid)
      next_word = alu_word;
  end

  ////////////////////////////////////////////////////////////
  // Result bus register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
      result_valid <= 1'b0;
    else
      result_valid <= next_valid;
  end

  always_ff @(posedge clock)
  begin
    if (next_valid)
      result <= next_word;
  end

  // An ALU word that lost the bus is presented again unchanged
  a_alu_held: assert property (
    @(posedge clock) disable iff (!rst_n)
    stall |=> alu_valid && (alu_word == $past(alu_word))
  );

endmodule

// File: hdl/ex_pkg.sv
/*
 * Execute stage package
 * Opcode enums, branch condition codes and the bus structs shared by the stage
 */
package ex_pkg;

  localparam int PHT_IDX_BITS = 8;  // Predictor table index width

  // ALU function select from decode
  typedef enum logic [4:0] {
    alu_addq   = 5'h00,
    alu_subq   = 5'h01,
    alu_and    = 5'h02,
    alu_bic    = 5'h03,
    alu_bis    = 5'h04,
    alu_ornot  = 5'h05,
    alu_xor    = 5'h06,
    alu_eqv    = 5'h07,
    alu_srl    = 5'h08,
    alu_sll    = 5'h09,
    alu_sra    = 5'h0a,
    alu_mulq   = 5'h0b,
    alu_cmpeq  = 5'h0c,
    alu_cmplt  = 5'h0d,
    alu_cmple  = 5'h0e,
    alu_cmpult = 5'h0f,
    alu_cmpule = 5'h10
  } alu_func_e;

  typedef enum logic [1:0] {
    opa_rega     = 2'd0,
    opa_mem_disp = 2'd1,
    opa_npc      = 2'd2,
    opa_not3     = 2'd3
  } opa_sel_e;

  // Code 3 is not a legal operand B select
  typedef enum logic [1:0] {
    opb_regb    = 2'd0,
    opb_alu_imm = 2'd1,
    opb_br_disp = 2'd2
  } opb_sel_e;

  // Branch conditions, taken from IR[28:26]
  typedef enum logic [2:0] {
    br_lbc = 3'd0,  // Low bit clear
    br_eq  = 3'd1,
    br_lt  = 3'd2,
    br_le  = 3'd3,
    br_lbs = 3'd4,  // Low bit set
    br_ne  = 3'd5,
    br_ge  = 3'd6,
    br_gt  = 3'd7
  } br_cond_e;

  typedef struct packed {
    logic                    valid;
    logic [63:0]             npc;       // PC + 4
    logic [63:0]             ppc;       // Predicted next PC
    logic [PHT_IDX_BITS-1:0] pht_idx;
    logic [31:0]             ir;
    logic [4:0]              dest_reg;
    logic [63:0]             rega;
    logic [63:0]             regb;
    opa_sel_e                opa_sel;
    opb_sel_e                opb_sel;
    alu_func_e               alu_func;
    logic                    cond_br;
    logic                    uncond_br;
    logic                    rd_mem;
    logic                    wr_mem;
  } ex_issue_t;

  typedef struct packed {
    logic [63:0]             npc;
    logic [4:0]              dest_reg;
    logic [63:0]             result;
    logic                    mispredict;
    logic [1:0]              branch_result;  // {is branch, taken}
    logic [PHT_IDX_BITS-1:0] pht_idx;
  } ex_result_t;

  typedef struct packed {
    logic [63:0] npc;
    logic [4:0]  dest_reg;
  } mult_tag_t;

  typedef struct packed {
    logic [4:0]  tag;
    logic [63:0] address;
    logic [63:0] value;   // Store data
  } lsq_req_t;

  typedef struct packed {
    logic [4:0]  tag;
    logic [63:0] value;
  } mem_wb_t;

endpackage

// File: hdl/ex_stage.sv
/*
 * Execute stage, single issue lane
 * Operand select, ALU, branch resolve, multiply, LSQ hand-off and result merge
 */
module ex_stage
  import ex_pkg::*;
#(
  parameter int MULT_STAGES = 4
) (
  input  logic       clock,
  input  logic       rst_n,
  input  ex_issue_t  issue,
  input  mem_wb_t    mem_wb,
  input  logic       mem_wb_valid,
  output logic       stall,
  output ex_result_t result,
  output logic       result_valid,
  output lsq_req_t   lsq_req,
  output logic       lsq_valid
);

  logic [63:0] mem_disp;
  logic [63:0] br_disp;
  logic [63:0] alu_imm;
  logic [63:0] opa;
  logic [63:0] opb;
  logic [63:0] alu_result;
  logic        is_mul;
  logic        is_mem;
  logic        is_branch;
  logic        alu_req;
  logic        mult_req;
  logic        taken;
  logic        mispredict;
  logic        arb_stall;
  logic        mult_freeze;
  mult_tag_t   mult_tag_in;
  mult_tag_t   mult_tag_out;
  logic [63:0] mult_product;
  logic        mult_out_valid;
  ex_result_t  alu_word;
  ex_result_t  mult_word;

  ////////////////////////////////////////////////////////////
  // Immediates and operand muxes
  ////////////////////////////////////////////////////////////

  assign mem_disp = {{48{issue.ir[15]}}, issue.ir[15:0]};
  assign br_disp  = {{41{issue.ir[20]}}, issue.ir[20:0], 2'b00};  // Word displacement
  assign alu_imm  = {56'b0, issue.ir[20:13]};

  always_comb
  begin
    case (issue.opa_sel)
      opa_rega:     opa = issue.rega;
      opa_mem_disp: opa = mem_disp;
      opa_npc:      opa = issue.npc;
      default:      opa = ~64'h3;
    endcase
  end

  always_comb
  begin
    case (issue.opb_sel)
      opb_regb:    opb = issue.regb;
      opb_alu_imm: opb = alu_imm;
      opb_br_disp: opb = br_disp;
      default:     opb = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Dispatch
  ////////////////////////////////////////////////////////////

  assign is_mul    = (issue.alu_func == alu_mulq);
  assign is_mem    = (issue.rd_mem | issue.wr_mem) & ~is_mul;
  assign is_branch = issue.cond_br | issue.uncond_br;

  assign alu_req  = issue.valid & ~is_mul & ~is_mem;  // Presented, not yet accepted
  assign mult_req = issue.valid & is_mul;

  // Frozen multiplier cannot take a new operand pair
  assign stall = arb_stall | (mult_req & mult_freeze);

  assign lsq_valid       = issue.valid & is_mem & ~stall;
  assign lsq_req.tag     = issue.dest_reg;
  assign lsq_req.address = alu_result;  // Base plus displacement
  assign lsq_req.value   = issue.rega;

  alu u_alu (
    .opa    (opa),
    .opb    (opb),
    .func   (issue.alu_func),
    .result (alu_result)
  );

  branch_unit u_branch (
    .rega       (issue.rega),
    .cond_code  (issue.ir[28:26]),
    .cond_br    (issue.cond_br),
    .uncond_br  (issue.uncond_br),
    .target     (alu_result),
    .npc        (issue.npc),
    .ppc        (issue.ppc),
    .taken      (taken),
    .mispredict (mispredict)
  );

  assign mult_tag_in.npc      = issue.npc;
  assign mult_tag_in.dest_reg = issue.dest_reg;

  mult #(
    .STAGES (MULT_STAGES),
    .tag_t  (mult_tag_t)
  ) u_mult (
    .clock     (clock),
    .rst_n     (rst_n),
    .mplier    (opa),
    .mcand     (opb),
    .tag_in    (mult_tag_in),
    .valid_in  (mult_req & ~stall),
    .freeze    (mult_freeze),
    .product   (mult_product),
    .tag_out   (mult_tag_out),
    .valid_out (mult_out_valid)
  );

  ////////////////////////////////////////////////////////////
  // Result words
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    alu_word               = '0;
    alu_word.npc           = issue.npc;
    alu_word.dest_reg      = issue.dest_reg;
    alu_word.result        = (is_branch && !taken) ? issue.npc : alu_result;
    alu_word.mispredict    = mispredict;
    alu_word.branch_result = {is_branch, taken};
    alu_word.pht_idx       = issue.pht_idx;
  end

  always_comb
  begin
    mult_word          = '0;
    mult_word.npc      = mult_tag_out.npc;
    mult_word.dest_reg = mult_tag_out.dest_reg;
    mult_word.result   = mult_product;
  end

  ex_arbiter u_arbiter (
    .clock        (clock),
    .rst_n        (rst_n),
    .alu_valid    (alu_req),
    .alu_word     (alu_word),
    .mult_valid   (mult_out_valid),
    .mult_word    (mult_word),
    .mem_wb_valid (mem_wb_valid),
    .mem_wb       (mem_wb),
    .stall        (arb_stall),
    .mult_freeze  (mult_freeze),
    .result       (result),
    .result_valid (result_valid)
  );

  // Decode never sends the unused operand B code
  a_opb_legal: assert property (
    @(posedge clock) disable iff (!rst_n)
    issue.valid |-> issue.opb_sel inside {opb_regb, opb_alu_imm, opb_br_disp}
  );

endmodule

// File: hdl/mult.sv
/*
 * Pipelined multiplier
 * One multiplier slice per stage; a tag rides along with each product
 */
module mult #(
  parameter int  STAGES = 4,
  parameter type tag_t  = logic [63:0]
) (
  input  logic        clock,
  input  logic        rst_n,
  input  logic [63:0] mplier,
  input  logic [63:0] mcand,
  input  tag_t        tag_in,
  input  logic        valid_in,
  input  logic        freeze,
  output logic [63:0] product,
  output tag_t        tag_out,
  output logic        valid_out
);

  localparam int SLICE = 64 / STAGES;  // Multiplier bits per stage

  if (64 % STAGES != 0)
  begin : g_bad_stages
    $error("mult: STAGES must divide 64");
  end

  logic [63:0]       prod_q   [STAGES];
  logic [63:0]       mplier_q [STAGES];
  logic [63:0]       mcand_q  [STAGES];
  tag_t              tag_q    [STAGES];
  logic [STAGES-1:0] valid_q;

  for (genvar i = 0; i < STAGES; i++)
  begin : g_stage
    logic [63:0] prod_in;
    logic [63:0] mplier_in;
    logic [63:0] mcand_in;
    tag_t        tag_s;
    logic        valid_s;

    if (i == 0)
    begin : g_first
      assign prod_in   = '0;
      assign mplier_in = mplier;
      assign mcand_in  = mcand;
      assign tag_s     = tag_in;
      assign valid_s   = valid_in;
    end
    else
    begin : g_next
      assign prod_in   = prod_q[i-1];
      assign mplier_in = mplier_q[i-1];
      assign mcand_in  = mcand_q[i-1];
      assign tag_s     = tag_q[i-1];
      assign valid_s   = valid_q[i-1];
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
      if (!rst_n)
        valid_q[i] <= 1'b0;
      else if (!freeze)
        valid_q[i] <= valid_s;
    end

    // Add this slice's partial product, shift the rest along
    always_ff @(posedge clock)
    begin
      if (!freeze)
      begin
        prod_q[i]   <= prod_in + mcand_in * {{(64-SLICE){1'b0}}, mplier_in[SLICE-1:0]};
        mplier_q[i] <= mplier_in >> SLICE;
        mcand_q[i]  <= mcand_in << SLICE;
        tag_q[i]    <= tag_s;
      end
    end
  end

  assign product   = prod_q[STAGES-1];
  assign tag_out   = tag_q[STAGES-1];
  assign valid_out = valid_q[STAGES-1];

endmodule

// File: list.f
+incdir+testbench
hdl/ex_pkg.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/mult.sv
hdl/ex_arbiter.sv
hdl/ex_stage.sv
testbench/tb_ex_stage.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the execute stage testbench
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module tb_ex_stage -o tb_ex_stage \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_ex_stage > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"

// File: testbench/tb_checks.svh
/*
 * Execute stage testbench checks
 * Reference models, typed compare tasks and the result wait loop
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////

function automatic logic [63:0] opa_of(input ex_issue_t op);
  case (op.opa_sel)
    opa_rega:     return op.rega;
    opa_mem_disp: return 64'($signed(op.ir[15:0]));
    opa_npc:      return op.npc;
    default:      return 64'hffff_ffff_ffff_fffc;  // Not 3
  endcase
endfunction

function automatic logic [63:0] opb_of(input ex_issue_t op);
  case (op.opb_sel)
    opb_regb:    return op.regb;
    opb_alu_imm: return 64'(op.ir[20:13]);
    default:     return 64'($signed(op.ir[20:0])) << 2;
  endcase
endfunction

function automatic logic [63:0] alu_ref(input alu_func_e f, input logic [63:0] a,
                                        input logic [63:0] b);
  logic [63:0] sa;
  logic [63:0] sb;
  logic [63:0] fill;
  // Flipping the sign bit turns a signed compare into an unsigned one
  sa = a ^ 64'h8000_0000_0000_0000;
  sb = b ^ 64'h8000_0000_0000_0000;
  fill = a[63] ? ~(64'hffff_ffff_ffff_ffff >> b[5:0]) : 64'd0;
  case (f)
    alu_addq:   return a + b;
    alu_subq:   return a - b;
    alu_and:    return a & b;
    alu_bic:    return a & ~b;
    alu_bis:    return a | b;
    alu_ornot:  return a | ~b;
    alu_xor:    return a ^ b;
    alu_eqv:    return ~(a ^ b);
    alu_srl:    return a >> b[5:0];
    alu_sll:    return a << b[5:0];
    alu_sra:    return (a >> b[5:0]) | fill;  // Sign bits fill from the top
    alu_cmpeq:  return 64'(a == b);
    alu_cmplt:  return 64'(sa < sb);
    alu_cmple:  return 64'(sa <= sb);
    alu_cmpult: return 64'(a < b);
    alu_cmpule: return 64'(a <= b);
    default:    return 64'd0;
  endcase
endfunction

function automatic logic cond_holds(input logic [2:0] code, input logic [63:0] v);
  case (code)
    3'd0:    return !v[0];
    3'd1:    return v == 64'd0;
    3'd2:    return v[63];
    3'd3:    return v[63] || v == 64'd0;
    3'd4:    return v[0];
    3'd5:    return v != 64'd0;
    3'd6:    return !v[63];
    default: return !v[63] && v != 64'd0;
  endcase
endfunction

// Result word an ALU, branch or multiply op should put on the bus
function automatic ex_result_t expected_word(input ex_issue_t op);
  ex_result_t w;
  logic [63:0] calc;
  logic        is_br;
  logic        taken;
  w = '0;
  w.npc = op.npc;
  w.dest_reg = op.dest_reg;
  if (op.alu_func == alu_mulq)
  begin
    w.result = opa_of(op) * opb_of(op);  // Low 64 bits only
    return w;
  end
  calc = alu_ref(op.alu_func, opa_of(op), opb_of(op));
  is_br = op.cond_br | op.uncond_br;
  taken = op.uncond_br | (op.cond_br & cond_holds(op.ir[28:26], op.rega));
  w.result = (is_br && !taken) ? op.npc : calc;
  w.mispredict = taken ? (calc != op.ppc) : (op.ppc != op.npc);
  w.branch_result = {is_br, taken};
  w.pht_idx = op.pht_idx;
  return w;
endfunction

function automatic ex_result_t mem_word_of(input mem_wb_t wb);
  ex_result_t w;
  w = '0;
  w.dest_reg = wb.tag;
  w.result = wb.value;
  return w;
endfunction

////////////////////////////////////////////////////////////
// Compare tasks and wait loop
////////////////////////////////////////////////////////////

task automatic check_result(input string what, input ex_result_t got, input ex_result_t exp);
  if (got !== exp)
  begin
    err_result++;
    $display("CHECK FAILED at %0t: %s word %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic check_lsq(input string what, input lsq_req_t got, input lsq_req_t exp);
  if (got !== exp)
  begin
    err_lsq++;
    $display("CHECK FAILED at %0t: %s %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
  if (got !== exp)
  begin
    err_flag++;
    $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
  end
endtask

// Cycle count runs from the issue edge of the op being waited on
task automatic wait_result(input int start, input int max_cycles, output int cycles);
  cycles = start;
  while (!result_valid && cycles < max_cycles)
  begin
    @(negedge clock);
    cycles++;
  end
  if (!result_valid)
  begin
    err_timeout++;
    $display("Timeout at %0t: no result word within %0d cycles", $time, max_cycles);
  end
endtask

`endif

// File: testbench/tb_ex_stage.sv
/*
 * Execute stage testbench
 * Directed ALU, branch, multiply, priority, LSQ and reset tests
 */
module tb_ex_stage
  import ex_pkg::*;
();

  localparam int CLK_PERIOD  = 100;
  localparam int MULT_STAGES = 4;
  localparam int MULT_LAT    = MULT_STAGES + 1;

  logic       clock;
  logic       rst_n;
  ex_issue_t  issue;
  mem_wb_t    mem_wb;
  logic       mem_wb_valid;
  logic       stall;
  ex_result_t result;
  logic       result_valid;
  lsq_req_t   lsq_req;
  logic       lsq_valid;
  logic [31:0] lfsr;
  int err_result = 0;
  int err_lsq = 0;
  int err_flag = 0;
  int err_timeout = 0;

  `include "tb_checks.svh"

  ex_stage #(
    .MULT_STAGES (MULT_STAGES)
  ) u_dut (
    .clock        (clock),
    .rst_n        (rst_n),
    .issue        (issue),
    .mem_wb       (mem_wb),
    .mem_wb_valid (mem_wb_valid),
    .stall        (stall),
    .result       (result),
    .result_valid (result_valid),
    .lsq_req      (lsq_req),
    .lsq_valid    (lsq_valid)
  );

  initial
  begin
    clock = 1'b0;
    forever #(CLK_PERIOD/2) clock = ~clock;
  end

  ////////////////////////////////////////////////////////////
  // Random stimulus
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] next_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[62:0], lfsr_step()};
    return v;
  endfunction

  function automatic logic [63:0] random_pc();
    logic [63:0] r;
    r = next_bits(62);
    return {r[61:0], 2'b00};  // Word aligned
  endfunction

  // Plain addq on registers, correctly predicted
  function automatic ex_issue_t random_issue();
    ex_issue_t op;
    logic [63:0] r;
    op = '0;
    op.valid = 1'b1;
    op.npc = random_pc();
    op.ppc = op.npc;
    r = next_bits(8);
    op.pht_idx = r[7:0];
    r = next_bits(32);
    op.ir = r[31:0];
    r = next_bits(5);
    op.dest_reg = r[4:0];
    op.rega = next_bits(64);
    op.regb = next_bits(64);
    op.alu_func = alu_addq;
    return op;
  endfunction

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  // Load data arriving in reset must not reach the result bus
  task automatic reset_outputs();
    rst_n = 1'b0;
    mem_wb_valid = 1'b1;
    repeat (16)
    begin
      @(negedge clock);
      check_bit("result_valid in reset", result_valid, 1'b0);
    end
    mem_wb_valid = 1'b0;
    rst_n = 1'b1;
  endtask

  // One ALU or branch op, result expected on the next edge
  task automatic run_single(input ex_issue_t op, input string what);
    ex_result_t exp;
    int cycles;
    exp = expected_word(op);
    @(negedge clock);
    issue = op;
    @(negedge clock);
    issue.valid = 1'b0;
    wait_result(1, 4, cycles);
    check_bit("single cycle latency", cycles == 1, 1'b1);
    check_result(what, result, exp);
  endtask

  task automatic exercise_alu();
    ex_issue_t op;
    logic [63:0] r;
    for (int f = 0; f <= 16; f++)
    begin
      for (int k = 0; k < 3; k++)
      begin
        op = random_issue();
        op.alu_func = alu_func_e'(f[4:0]);
        r = next_bits(4);
        op.opa_sel = opa_sel_e'(r[1:0]);
        op.opb_sel = (r[3:2] == 2'd3) ? opb_regb : opb_sel_e'(r[3:2]);
        r = next_bits(2);
        if (r[0])
          op.regb = op.rega;  // Equal operands for the compares
        if (r[1])
          op.ppc = random_pc();
        if (op.alu_func != alu_mulq)
          run_single(op, op.alu_func.name());
      end
    end
  endtask

  task automatic resolve_branches();
    ex_issue_t op;
    logic [63:0] r;
    logic [63:0] target;
    logic [63:0] vals [4];
    for (int c = 0; c < 10; c++)
    begin
      r = next_bits(64);
      vals[0] = 64'd0;
      vals[1] = {1'b1, r[62:0]};          // Negative
      vals[2] = {1'b0, r[62:1], 1'b1};    // Odd positive
      vals[3] = {1'b0, r[62:2], 2'b10};   // Even positive
      for (int v = 0; v < 4; v++)
      begin
        op = random_issue();
        op.ir[28:26] = c[2:0];
        op.rega = vals[v];
        op.opa_sel = opa_npc;
        op.opb_sel = opb_br_disp;
        op.cond_br = (c < 8);
        op.uncond_br = (c >= 8);  // Last two rounds are unconditional
        target = alu_ref(alu_addq, opa_of(op), opb_of(op));
        r = next_bits(1);
        op.ppc = r[0] ? target : op.npc;
        run_single(op, "branch");
      end
    end
  endtask

  task automatic multiply_back_to_back();
    ex_issue_t ops [3];
    logic [63:0] r;
    int cycles;
    int now;
    for (int k = 0; k < 3; k++)
    begin
      ops[k] = random_issue();
      ops[k].alu_func = alu_mulq;
      r = next_bits(3);
      ops[k].opa_sel = opa_sel_e'(r[1:0]);
      ops[k].opb_sel = r[2] ? opb_alu_imm : opb_regb;
    end
    for (int k = 0; k < 3; k++)
    begin
      @(negedge clock);
      issue = ops[k];
    end
    @(negedge clock);
    issue.valid = 1'b0;
    now = 3;  // Cycles since the first multiply
    for (int k = 0; k < 3; k++)
    begin
      if (k > 0)
      begin
        @(negedge clock);
        now++;
      end
      wait_result(now - k, MULT_LAT + 4, cycles);
      now = cycles + k;
      check_bit("multiply latency", cycles == MULT_LAT, 1'b1);
      check_result("multiply", result, expected_word(ops[k]));
    end
  endtask

  task automatic writeback_priority();
    ex_issue_t op;
    mem_wb_t wb;
    logic [63:0] r;
    int cycles;
    // Load data and an ALU op arrive together
    op = random_issue();
    op.alu_func = alu_xor;
    r = next_bits(5);
    wb.tag = r[4:0];
    wb.value = next_bits(64);
    @(negedge clock);
    issue = op;
    mem_wb = wb;
    mem_wb_valid = 1'b1;
    #(CLK_PERIOD/4);
    check_bit("stall under writeback", stall, 1'b1);
    @(negedge clock);
    mem_wb_valid = 1'b0;
    check_bit("writeback result_valid", result_valid, 1'b1);
    check_result("writeback", result, mem_word_of(wb));
    #(CLK_PERIOD/4);
    check_bit("stall released", stall, 1'b0);
    @(negedge clock);
    issue.valid = 1'b0;
    wait_result(1, 4, cycles);
    check_bit("held op latency", cycles == 1, 1'b1);
    check_result("held alu op", result, expected_word(op));

    // Load data lands while a product sits in the last stage
    op = random_issue();
    op.alu_func = alu_mulq;
    r = next_bits(5);
    wb.tag = r[4:0];
    wb.value = next_bits(64);
    @(negedge clock);
    issue = op;
    @(negedge clock);
    issue.valid = 1'b0;
    repeat (MULT_STAGES - 1) @(negedge clock);
    mem_wb = wb;
    mem_wb_valid = 1'b1;
    @(negedge clock);
    mem_wb_valid = 1'b0;
    check_bit("writeback over multiply", result_valid, 1'b1);
    check_result("writeback over multiply", result, mem_word_of(wb));
    @(negedge clock);
    wait_result(MULT_LAT + 1, MULT_LAT + 4, cycles);
    check_bit("frozen multiply latency", cycles == MULT_LAT + 1, 1'b1);
    check_result("frozen multiply", result, expected_word(op));
    @(negedge clock);
    check_bit("product sent once", result_valid, 1'b0);
  endtask

  task automatic memory_requests();
    ex_issue_t op;
    lsq_req_t exp;
    mem_wb_t wb;
    logic [63:0] r;
    for (int k = 0; k < 4; k++)
    begin
      op = random_issue();
      op.opa_sel = opa_mem_disp;
      op.opb_sel = opb_regb;
      if (k[0])
        op.wr_mem = 1'b1;
      else
        op.rd_mem = 1'b1;
      exp.tag = op.dest_reg;
      exp.address = opa_of(op) + op.regb;  // Displacement plus base
      exp.value = op.rega;
      r = next_bits(5);
      wb.tag = r[4:0];
      wb.value = next_bits(64);
      @(negedge clock);
      issue = op;
      mem_wb = wb;
      mem_wb_valid = k[1];  // Second pair shares the cycle with load data
      #(CLK_PERIOD/4);
      check_bit("lsq_valid on issue", lsq_valid, 1'b1);
      check_bit("stall on memory op", stall, 1'b0);
      check_lsq("lsq request", lsq_req, exp);
      @(negedge clock);
      issue.valid = 1'b0;
      mem_wb_valid = 1'b0;
      if (k[1])
      begin
        check_bit("writeback beside memory op", result_valid, 1'b1);
        check_result("writeback beside memory op", result, mem_word_of(wb));
        @(negedge clock);
      end
      repeat (3)
      begin
        check_bit("no result for memory op", result_valid, 1'b0);
        @(negedge clock);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    issue = '0;
    mem_wb = '0;
    mem_wb_valid = 1'b0;
    rst_n = 1'b0;
    lfsr = 32'd81;
    reset_outputs();
    exercise_alu();
    resolve_branches();
    multiply_back_to_back();
    writeback_priority();
    memory_requests();
    @(negedge clock);
    $display("Errors: result %0d, lsq %0d, flag %0d, timeout %0d",
             err_result, err_lsq, err_flag, err_timeout);
    if (err_result + err_lsq + err_flag + err_timeout == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule
